//--- verilog/pcoeffPkg.sv
package pcoeffPkg;

    // truth table of a seven variable function.
    localparam int funcBits = 128;
    localparam int indexBits = 7;   // bits of one truth table position.

    localparam int sumBits = 38;    // running sum of terms.
    localparam int countBits = 3;   // number of contributing bots modulo 8.

    // one difference mask has at most 64 components.
    localparam int termBits = 7;

    // one item as it enters the pipeline.
    typedef struct packed {
        logic startNewTop;
        logic [funcBits-1:0] bot;
    } inItemT;

    // outcome of the check of a bot against the current top.
    typedef struct packed {
        logic startNewTop;
        logic isSubset;
        logic [funcBits-1:0] diff;  // top and not bot.
    } diffItemT;

    typedef struct packed {
        logic [sumBits-1:0] summedData;
        logic [countBits-1:0] pcoeffCount;
    } resultT;

    // flood-fill engine states.
    // seed isolates one position, expand grows it, finish removes the component.
    typedef enum logic [1:0] {
        idle,
        seed,
        expand,
        finish
    } counterStateT;

endpackage

//--- verilog/pipeControl.sv
`timescale 1ns/1ns

module pipeControl (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  pcoeffPkg::inItemT inItem,
    output logic inReady,
    output pcoeffPkg::inItemT heldItem,
    input  logic counterBusy,
    input  logic counterDone,
    input  pcoeffPkg::diffItemT diffInfo,
    output logic start,
    output logic pendStartNewTop,
    output logic pendSubset,
    input  logic outReady,
    output logic outValid
);

    logic heldFull;     // stage 1 holds an item.
    logic inTake;
    logic outTake;
    logic resultBlock;

    assign inTake = inValid && inReady;    // item transfer on this edge.
    assign outTake = outValid && outReady; // result transfer on this edge.

    // a result left unread, or one that shows up next cycle, keeps the counter waiting.
    assign resultBlock = counterDone || (outValid && !outReady);

    assign start = heldFull && !counterBusy && !resultBlock;

    // stage 1 empties in the same cycle its item goes to the counter.
    assign inReady = !heldFull || start;

    always_ff @(posedge clk) begin
        if (!rst) begin
            heldFull <= 1'b0;
        end else begin
            heldFull <= inTake || (heldFull && !start);
        end
    end

    // stage 1 holding register.
    always_ff @(posedge clk) begin
        if (inTake) begin
            heldItem <= inItem;
        end
    end

    // flags of the job now in the counter are used when its term comes back.
    always_ff @(posedge clk) begin
        if (!rst) begin
            pendStartNewTop <= 1'b0;
            pendSubset <= 1'b0;
        end else if (start) begin
            pendStartNewTop <= diffInfo.startNewTop;
            pendSubset <= diffInfo.isSubset;
        end
    end

    // the result is latched on done and shown from the next cycle.
    always_ff @(posedge clk) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else if (counterDone) begin
            outValid <= 1'b1;
        end else if (outTake) begin
            outValid <= 1'b0;
        end
    end

endmodule

//--- verilog/topSubsetStage.sv
`timescale 1ns/1ns

module topSubsetStage (
    input  logic clk,
    input  logic rst,
    input  pcoeffPkg::inItemT heldItem,
    input  logic load,
    output pcoeffPkg::diffItemT diffInfo
);

    logic [pcoeffPkg::funcBits-1:0] top;
    logic [pcoeffPkg::funcBits-1:0] checkTop;   // top the held bot is compared with.
    logic [pcoeffPkg::funcBits-1:0] outside;    // bot positions missing from the top.

    // a new top is checked against itself.
    assign checkTop = heldItem.startNewTop ? heldItem.bot : top;

    assign outside = heldItem.bot & ~checkTop;

    assign diffInfo.startNewTop = heldItem.startNewTop;
    assign diffInfo.isSubset = (outside == '0);
    assign diffInfo.diff = checkTop & ~heldItem.bot;

    // top is replaced when the flagged item is sent to the counter.
    always_ff @(posedge clk) begin
        if (!rst) begin
            top <= '0;
        end else if (load && heldItem.startNewTop) begin
            top <= heldItem.bot;
        end
    end

endmodule

//--- verilog/componentCounter.sv
`timescale 1ns/1ns

module componentCounter (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [pcoeffPkg::funcBits-1:0] mask,
    output logic busy,
    output logic done,
    output logic [pcoeffPkg::termBits-1:0] term
);

    pcoeffPkg::counterStateT state;

    logic [pcoeffPkg::funcBits-1:0] remaining;  // positions not yet in a counted component.
    logic [pcoeffPkg::funcBits-1:0] region;     // component being flooded.
    logic [pcoeffPkg::funcBits-1:0] grown;
    logic [pcoeffPkg::funcBits-1:0] lowest;
    logic [pcoeffPkg::termBits-1:0] count;
    logic empty;
    logic stable;

    // positions one index bit away from any position of the region.
    function automatic logic [pcoeffPkg::funcBits-1:0] neighbours(
        input logic [pcoeffPkg::funcBits-1:0] r
    );
        logic [pcoeffPkg::funcBits-1:0] nb;
        nb = '0;
        for (int p = 0; p < pcoeffPkg::funcBits; p++) begin
            for (int k = 0; k < pcoeffPkg::indexBits; k++) begin
                nb[p] = nb[p] | r[p ^ (1 << k)];
            end
        end
        return nb;
    endfunction

    // two's complement trick keeps only the lowest set bit.
    assign lowest = remaining & (~remaining + 1'b1);

    assign grown = (region | neighbours(region)) & remaining;

    assign empty = (remaining == '0);
    assign stable = (grown == region); // flood has reached the whole component.

    assign busy = (state != pcoeffPkg::idle);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= pcoeffPkg::idle;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                pcoeffPkg::idle: begin
                    if (start) begin
                        state <= pcoeffPkg::seed;
                    end
                end
                pcoeffPkg::seed: begin
                    if (empty) begin
                        done <= 1'b1;
                        state <= pcoeffPkg::idle;
                    end else begin
                        state <= pcoeffPkg::expand;
                    end
                end
                pcoeffPkg::expand: begin
                    if (stable) begin
                        state <= pcoeffPkg::finish;
                    end
                end
                pcoeffPkg::finish: begin
                    state <= pcoeffPkg::seed;
                end
                default: begin
                    state <= pcoeffPkg::idle;
                end
            endcase
        end
    end

    // masks, count and term follow the state.
    always_ff @(posedge clk) begin
        case (state)
            pcoeffPkg::idle: begin
                if (start) begin
                    remaining <= mask;
                    count <= '0;
                end
            end
            pcoeffPkg::seed: begin
                region <= lowest;
                if (empty) begin
                    term <= count;  // valid together with done.
                end
            end
            pcoeffPkg::expand: begin
                region <= grown;
            end
            pcoeffPkg::finish: begin
                remaining <= remaining & ~region;
                count <= count + 1'b1;
            end
            default: begin
                region <= '0;
            end
        endcase
    end

endmodule

//--- verilog/groupAccumulator.sv
`timescale 1ns/1ns

module groupAccumulator (
    input  logic clk,
    input  logic rst,
    input  logic done,
    input  logic [pcoeffPkg::termBits-1:0] term,
    input  logic startNewTop,
    input  logic isSubset,
    output pcoeffPkg::resultT result
);

    logic [pcoeffPkg::sumBits-1:0] baseSum;       // totals before this bot.
    logic [pcoeffPkg::countBits-1:0] baseCount;
    logic [pcoeffPkg::sumBits-1:0] termWide;
    pcoeffPkg::resultT nextResult;

    // a new top opens a fresh group.
    assign baseSum = startNewTop ? '0 : result.summedData;
    assign baseCount = startNewTop ? '0 : result.pcoeffCount;

    assign termWide = {{(pcoeffPkg::sumBits - pcoeffPkg::termBits){1'b0}}, term};

    always_comb begin
        nextResult.summedData = baseSum;
        nextResult.pcoeffCount = baseCount;
        if (isSubset) begin
            nextResult.summedData = baseSum + termWide;
            nextResult.pcoeffCount = baseCount + 1'b1; // wraps modulo 8.
        end
    end

    // the totals register is also the result shown at the output.
    always_ff @(posedge clk) begin
        if (!rst) begin
            result <= '0;
        end else if (done) begin
            result <= nextResult;
        end
    end

endmodule

//--- verilog/pcoeffPipeline.sv
`timescale 1ns/1ns

module pcoeffPipeline (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  pcoeffPkg::inItemT inItem,
    output logic inReady,
    output logic outValid,
    input  logic outReady,
    output pcoeffPkg::resultT result
);

    pcoeffPkg::inItemT heldItem;        // stage 1 item.
    pcoeffPkg::diffItemT diffInfo;

    logic start;
    logic counterBusy;
    logic counterDone;
    logic pendStartNewTop;
    logic pendSubset;
    logic [pcoeffPkg::termBits-1:0] term;

    pipeControl u_pipeControl (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inItem(inItem),
        .inReady(inReady),
        .heldItem(heldItem),
        .counterBusy(counterBusy),
        .counterDone(counterDone),
        .diffInfo(diffInfo),
        .start(start),
        .pendStartNewTop(pendStartNewTop),
        .pendSubset(pendSubset),
        .outReady(outReady),
        .outValid(outValid)
    );

    topSubsetStage u_topSubsetStage (
        .clk(clk),
        .rst(rst),
        .heldItem(heldItem),
        .load(start),                   // top moves on when its item starts counting.
        .diffInfo(diffInfo)
    );

    componentCounter u_componentCounter (
        .clk(clk),
        .rst(rst),
        .start(start),
        .mask(diffInfo.diff),
        .busy(counterBusy),
        .done(counterDone),
        .term(term)
    );

    groupAccumulator u_groupAccumulator (
        .clk(clk),
        .rst(rst),
        .done(counterDone),
        .term(term),
        .startNewTop(pendStartNewTop),
        .isSubset(pendSubset),
        .result(result)
    );

endmodule

//--- bench/pcoeffPipelineTb.sv
`timescale 1ns/1ns

module pcoeffPipelineTb;

    localparam logic [4:0] numItems = 5'd19;
    localparam int watchdogCycles = int'(numItems) * 2000;  // generous bound per item.

    logic clk;
    logic rst;
    logic inValid;
    pcoeffPkg::inItemT inItem;
    logic inReady;
    logic outValid;
    logic outReady;
    pcoeffPkg::resultT result;

    // each item takes four words for flag, bot, expected sum and expected count.
    logic [127:0] stimMem [0:127];
    logic [7:0] lfsrState;
    int errorCount;
    int checkCount;

    pcoeffPipeline u_pcoeffPipeline (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inItem(inItem),
        .inReady(inReady),
        .outValid(outValid),
        .outReady(outReady),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci LFSR with taps x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic nextRandomBit(output logic b);
        lfsrState = lfsrStep(lfsrState);
        b = lfsrState[0];
    endtask

    task automatic compareValue(
        input string name,
        input logic [127:0] got,
        input logic [127:0] expected,
        input logic [4:0] item
    );
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("** Error: %s is %0h, expected %0h (item %0d)", name, got, expected, item);
        end
    endtask

    initial begin : mainFlow
        logic gapBit;
        logic stallBitA;
        logic stallBitB;
        logic [4:0] inPos;      // next item to offer.
        logic [4:0] outPos;     // next result expected.
        logic inTaken;
        logic waiting;          // a result sat unread in the last cycle.
        pcoeffPkg::resultT heldResult;

        rst = 1'b0;
        inValid = 1'b0;
        inItem = '0;
        outReady = 1'b0;
        lfsrState = 8'd89;
        errorCount = 0;
        checkCount = 0;
        inPos = '0;
        outPos = '0;
        inTaken = 1'b0;
        waiting = 1'b0;
        heldResult = '0;
        $readmemh("bench/pcoeffInput.mem", stimMem);

        repeat (4) @(negedge clk);
        rst = 1'b1;
        #1;
        compareValue("inReady", 128'(inReady), 128'd1, 5'd0);
        compareValue("outValid", 128'(outValid), 128'd0, 5'd0);

        while (outPos < numItems) begin
            @(negedge clk);
            if (inTaken) begin
                inValid = 1'b0;
                inTaken = 1'b0;
            end
            if (!inValid && inPos < numItems) begin
                nextRandomBit(gapBit);
                if (!gapBit) begin
                    inItem.startNewTop = stimMem[{inPos, 2'd0}][0];
                    inItem.bot = stimMem[{inPos, 2'd1}];
                    inValid = 1'b1;
                end
            end
            nextRandomBit(stallBitA);
            nextRandomBit(stallBitB);
            outReady = !(stallBitA && stallBitB);   // stalls about one cycle in four.
            #1;
            // transfers that happen on the coming rising edge.
            if (inValid && inReady) begin
                inTaken = 1'b1;
                inPos = inPos + 1'b1;
            end
            if (outValid) begin
                if (waiting) begin
                    compareValue("result.summedData (held)", 128'(result.summedData),
                        128'(heldResult.summedData), outPos);
                    compareValue("result.pcoeffCount (held)", 128'(result.pcoeffCount),
                        128'(heldResult.pcoeffCount), outPos);
                end
                if (outReady) begin
                    compareValue("result.summedData", 128'(result.summedData),
                        stimMem[{outPos, 2'd2}], outPos);
                    compareValue("result.pcoeffCount", 128'(result.pcoeffCount),
                        stimMem[{outPos, 2'd3}], outPos);
                    outPos = outPos + 1'b1;
                    waiting = 1'b0;
                end else begin
                    waiting = 1'b1;
                    heldResult = result;
                end
            end else if (waiting) begin
                // an unread result must keep outValid high.
                compareValue("outValid (held)", 128'(outValid), 128'd1, outPos);
                waiting = 1'b0;
            end
        end

        // no result may follow the last one.
        repeat (20) begin
            @(negedge clk);
            outReady = 1'b1;
            #1;
            if (outValid) begin
                errorCount++;
                $display("an extra result showed up after the last item was answered");
            end
        end

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("the run timed out after %0d cycles before all results came back",
            watchdogCycles);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- bench/pcoeffInput.mem
// columns: startNewTop, bot (128-bit truth table), expected summedData, expected pcoeffCount
// all hex, one item per line
// group with a full top: single, adjacent pair, distant pair, full hypercube
1 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000000000 1
0 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFE 0000000001 2
0 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFC 0000000002 3
0 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF6 0000000004 4
0 00000000000000000000000000000000 0000000005 5
// small top, non-subset bots and a count that wraps
1 0000000000000000000000000000000F 0000000000 1
0 00000000000000000000000000000010 0000000000 1
0 00000000000000000000000000000000 0000000001 2
0 00000000000000000000000000000006 0000000003 3
0 00000000000000000000000000000001 0000000004 4
0 0000000000000000000000000000000F 0000000004 5
0 00000000000000000000000000000009 0000000006 6
0 0000000000000000000000000000000F 0000000006 7
0 00000000000000000000000000000008 0000000007 0
0 0000000000000000000000000000001F 0000000007 0
0 0000000000000000000000000000000E 0000000008 1
// checkerboard difference with 64 isolated positions
1 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0000000000 1
0 96696996699696696996966996696996 0000000040 2
0 96696996699696696996966996696996 0000000080 3

//--- filelist.f
verilog/pcoeffPkg.sv
verilog/pipeControl.sv
verilog/topSubsetStage.sv
verilog/componentCounter.sv
verilog/groupAccumulator.sv
verilog/pcoeffPipeline.sv
bench/pcoeffPipelineTb.sv

//--- runSim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module pcoeffPipelineTb -f filelist.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation run failed"
cat sim.log 2>/dev/null
grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
